//--- hdl/emesh_defines.svh
// emesh transaction buffer build constants
// fifo sizing and almost-full threshold
`ifndef EMESH_DEFINES_SVH
`define EMESH_DEFINES_SVH

//##################################################
// fifo geometry
//##################################################

// packet slots in the fifo, power of two
`define EMESH_FIFO_DEPTH 16

// occupancy at which almost_full rises
`define EMESH_PROG_FULL 12

`endif

//--- hdl/emesh_fifo_top.sv
// emesh transaction buffer top level
// encoder, synchronous fifo and decoder behind plain valid/ready ports
`timescale 1ns/1ps
`include "emesh_defines.svh"

module emesh_fifo_top
   (
   input  logic                                 clk,
   input  logic                                 nreset,
   input  logic                                 clear,
   // access in
   input  logic                                 in_valid,
   output logic                                 in_ready,
   input  logic                                 in_write,
   input  emesh_pkg::datamode_t                 in_datamode,
   input  emesh_pkg::ctrlmode_t                 in_ctrlmode,
   input  emesh_pkg::addr_t                     in_dstaddr,
   input  emesh_pkg::data_t                     in_data,
   input  emesh_pkg::addr_t                     in_srcaddr,
   // access out
   output logic                                 out_valid,
   input  logic                                 out_ready,
   output logic                                 out_write,
   output emesh_pkg::datamode_t                 out_datamode,
   output emesh_pkg::ctrlmode_t                 out_ctrlmode,
   output emesh_pkg::addr_t                     out_dstaddr,
   output emesh_pkg::data_t                     out_data,
   output emesh_pkg::addr_t                     out_srcaddr,
   // occupancy
   output logic                                 almost_full,
   output logic [$clog2(`EMESH_FIFO_DEPTH):0]   fifo_level
   );

   localparam int CW = $clog2(`EMESH_FIFO_DEPTH) + 1;  // count width

   fifo_wr_if #(.T(emesh_pkg::packet_t))           wr_if ();
   fifo_rd_if #(.T(emesh_pkg::packet_t), .AW(CW))  rd_if ();

   assign almost_full = wr_if.prog_full;
   assign fifo_level  = rd_if.count;

   //##################################################
   // datapath
   //##################################################
   packet_encoder enc_i
   (
      .clk, .nreset, .clear,
      .in_valid, .in_ready, .in_write, .in_datamode,
      .in_ctrlmode, .in_dstaddr, .in_data, .in_srcaddr,
      .wr (wr_if.producer)
   );

   fifo_sync #(.T         (emesh_pkg::packet_t),
               .DEPTH     (`EMESH_FIFO_DEPTH),
               .PROG_FULL (`EMESH_PROG_FULL)) fifo_i
   (
      .clk, .nreset, .clear,
      .wr (wr_if.fifo),
      .rd (rd_if.fifo)
   );

   packet_decoder dec_i
   (
      .clk, .nreset, .clear,
      .rd (rd_if.consumer),
      .out_valid, .out_ready, .out_write, .out_datamode,
      .out_ctrlmode, .out_dstaddr, .out_data, .out_srcaddr
   );

endmodule

//--- hdl/emesh_pkg.sv
// emesh packet format
// field types and the 104-bit packed transaction
package emesh_pkg;

   // access size
   typedef enum logic [1:0]
   {
      DM_BYTE   = 2'b00,
      DM_HALF   = 2'b01,
      DM_WORD   = 2'b10,
      DM_DOUBLE = 2'b11
   } datamode_t;

   typedef logic [4:0]  ctrlmode_t;   // routing/control hints
   typedef logic [31:0] addr_t;       // dst/src address
   typedef logic [31:0] data_t;       // write payload

   //##################################################
   // packet layout, msb first
   //##################################################
   typedef struct packed
   {
      logic      write;      // 1 = write, 0 = read
      datamode_t datamode;
      ctrlmode_t ctrlmode;
      addr_t     dstaddr;
      data_t     data;       // zero on reads
      addr_t     srcaddr;    // return address for reads
   } packet_t;

endpackage

//--- hdl/fifo_rd_if.sv
// fifo read-side interface
// consumer pops with rd_en, dout follows one cycle later
`timescale 1ns/1ps

interface fifo_rd_if
  #(parameter type T  = logic,   // payload type
    parameter int  AW = 5);      // count width

   logic          rd_en;   // read strobe, ignored when empty
   T              dout;    // valid the cycle after a read
   logic          empty;   // nothing stored
   logic [AW-1:0] count;   // entries held

   // decoder side
   modport consumer
   (
      output rd_en,
      input  dout,
      input  empty,
      input  count
   );

   // buffer side
   modport fifo
   (
      input  rd_en,
      output dout,
      output empty,
      output count
   );

endinterface

//--- hdl/fifo_sync.sv
// synchronous fifo on a dual-port memory
// wrap-bit pointers, occupancy count, programmable almost-full
`timescale 1ns/1ps

module fifo_sync
  #(parameter type T         = logic,      // payload type
    parameter int  DEPTH     = 16,         // slots, power of two
    parameter int  PROG_FULL = DEPTH - 1)  // prog_full threshold
   (
   input  logic    clk,
   input  logic    nreset,   // async, active low
   input  logic    clear,    // sync flush of the whole fifo
   fifo_wr_if.fifo wr,
   fifo_rd_if.fifo rd
   );

   localparam int PW = $clog2(DEPTH);  // address width
   localparam int AW = PW + 1;         // count width, holds DEPTH

   logic [PW:0]   wr_ptr;  // msb is the wrap bit
   logic [PW:0]   rd_ptr;
   logic [AW-1:0] count;
   logic          fifo_write;
   logic          fifo_read;
   logic          ptr_match;

   //##################################################
   // flags
   //##################################################
   assign fifo_write = wr.wr_en & ~wr.full;
   assign fifo_read  = rd.rd_en & ~rd.empty;
   assign ptr_match  = (wr_ptr[PW-1:0] == rd_ptr[PW-1:0]);

   // same slot: wrap bits tell full from empty
   assign wr.full  = ptr_match & (wr_ptr[PW] != rd_ptr[PW]);
   assign rd.empty = ptr_match & (wr_ptr[PW] == rd_ptr[PW]);

   assign wr.prog_full = (count >= AW'(PROG_FULL));
   assign rd.count     = count;

   //##################################################
   // pointers and count
   //##################################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else if (clear)
      begin
         wr_ptr <= '0;  // drop everything stored
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (fifo_write)
            wr_ptr <= wr_ptr + 1'b1;
         if (fifo_read)
            rd_ptr <= rd_ptr + 1'b1;
         case ({fifo_write, fifo_read})
            2'b10:   count <= count + 1'b1;  // lone write
            2'b01:   count <= count - 1'b1;  // lone read
            default: count <= count;         // both or neither
         endcase
      end
   end

   // output is registered in the ram, empty needs no delay stage
   mem_dp #(.T(T), .DEPTH(DEPTH)) mem_i
   (
      .clk     (clk),
      .wr_en   (fifo_write),
      .wr_addr (wr_ptr[PW-1:0]),
      .wr_din  (wr.din),
      .rd_en   (fifo_read),
      .rd_addr (rd_ptr[PW-1:0]),
      .rd_dout (rd.dout)
   );

   //##################################################
   // protocol checks
   //##################################################
   a_no_write_full : assert property (@(posedge clk) disable iff (!nreset)
      !(wr.wr_en && wr.full))
      else $error("fifo_sync: write while full");

   a_no_read_empty : assert property (@(posedge clk) disable iff (!nreset)
      !(rd.rd_en && rd.empty))
      else $error("fifo_sync: read while empty");

   // pointer flags agree with the counter, so never both high
   a_flags_count : assert property (@(posedge clk) disable iff (!nreset)
      (wr.full == (count == AW'(DEPTH))) && (rd.empty == (count == '0)))
      else $error("fifo_sync: full/empty disagree with count");

endmodule

//--- hdl/fifo_wr_if.sv
// fifo write-side interface
// producer pushes with wr_en, fifo reports full/prog_full
`timescale 1ns/1ps

interface fifo_wr_if
  #(parameter type T = logic);   // payload type

   logic wr_en;      // write strobe, ignored when full
   T     din;        // payload to store
   logic full;       // no free slot
   logic prog_full;  // occupancy at threshold

   // encoder side
   modport producer
   (
      output wr_en,
      output din,
      input  full,
      input  prog_full
   );

   // buffer side
   modport fifo
   (
      input  wr_en,
      input  din,
      output full,
      output prog_full
   );

endinterface

//--- hdl/mem_dp.sv
// generic dual-port memory
// one write port, one read port with registered output
`timescale 1ns/1ps

module mem_dp
  #(parameter type T     = logic,  // word type
    parameter int  DEPTH = 16,     // words
    localparam int AW    = $clog2(DEPTH))
   (
   input  logic          clk,
   // write port
   input  logic          wr_en,
   input  logic [AW-1:0] wr_addr,
   input  T              wr_din,
   // read port
   input  logic          rd_en,
   input  logic [AW-1:0] rd_addr,
   output T              rd_dout    // next cycle after rd_en
   );

   T mem [DEPTH];  // storage array

   //##################################################
   // write port
   //##################################################
   always_ff @(posedge clk)
   begin
      if (wr_en)
      begin
         mem[wr_addr] <= wr_din;
      end
   end

   //##################################################
   // read port
   //##################################################
   // output register holds its word until the next read
   always_ff @(posedge clk)
   begin
      if (rd_en)
      begin
         rd_dout <= mem[rd_addr];  // one-cycle latency
      end
   end

endmodule

//--- hdl/packet_decoder.sv
// fifo to access decoder
// reads the fifo into a two-entry skid store and unpacks the head
`timescale 1ns/1ps

module packet_decoder
   (
   input  logic                  clk,
   input  logic                  nreset,
   input  logic                  clear,
   // fifo read side
   fifo_rd_if.consumer           rd,
   // access output, valid/ready
   output logic                  out_valid,
   input  logic                  out_ready,
   output logic                  out_write,
   output emesh_pkg::datamode_t  out_datamode,
   output emesh_pkg::ctrlmode_t  out_ctrlmode,
   output emesh_pkg::addr_t      out_dstaddr,
   output emesh_pkg::data_t      out_data,
   output emesh_pkg::addr_t      out_srcaddr
   );

   emesh_pkg::packet_t store [2];  // skid entries
   emesh_pkg::packet_t head_pkt;
   logic               head;       // next entry to send
   logic               tail;       // next entry to fill
   logic [1:0]         cnt;        // entries held, 0..2
   logic [1:0]         claimed;    // held plus in flight
   logic               pending;    // rd.dout valid this cycle
   logic               push;
   logic               pop;

   //##################################################
   // read issue
   //##################################################
   assign out_valid = (cnt != 2'd0);
   assign pop       = out_valid & out_ready;
   assign push      = pending;
   assign claimed   = cnt + {1'b0, pending};

   // room for one more once this cycle settles, pop frees a slot
   assign rd.rd_en = ~rd.empty & ((claimed < 2'd2) | pop);

   //##################################################
   // store control
   //##################################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         pending <= 1'b0;
         head    <= 1'b0;
         tail    <= 1'b0;
         cnt     <= 2'd0;
      end
      else if (clear)
      begin
         pending <= 1'b0;  // in-flight word is dropped
         head    <= 1'b0;
         tail    <= 1'b0;
         cnt     <= 2'd0;
      end
      else
      begin
         pending <= rd.rd_en;  // ram latency is one cycle
         if (push)
            tail <= ~tail;
         if (pop)
            head <= ~head;
         case ({push, pop})
            2'b10:   cnt <= cnt + 1'b1;
            2'b01:   cnt <= cnt - 1'b1;
            default: cnt <= cnt;
         endcase
      end
   end

   // capture ram output
   always_ff @(posedge clk)
   begin
      if (push)
         store[tail] <= rd.dout;
   end

   //##################################################
   // unpack
   //##################################################
   assign head_pkt     = store[head];
   assign out_write    = head_pkt.write;
   assign out_datamode = head_pkt.datamode;
   assign out_ctrlmode = head_pkt.ctrlmode;
   assign out_dstaddr  = head_pkt.dstaddr;
   assign out_data     = head_pkt.data;
   assign out_srcaddr  = head_pkt.srcaddr;

   // a read issued now must find a free slot when it lands
   a_store_room : assert property (@(posedge clk) disable iff (!nreset || clear)
      rd.rd_en |=> (clear || cnt < 2'd2 || pop))
      else $error("packet_decoder: skid store overflow");

endmodule

//--- hdl/packet_encoder.sv
// access to packet encoder
// packs each accepted access and stages it for the fifo write port
`timescale 1ns/1ps

module packet_encoder
   (
   input  logic                 clk,
   input  logic                 nreset,
   input  logic                 clear,
   // access input, valid/ready
   input  logic                 in_valid,
   output logic                 in_ready,
   input  logic                 in_write,
   input  emesh_pkg::datamode_t in_datamode,
   input  emesh_pkg::ctrlmode_t in_ctrlmode,
   input  emesh_pkg::addr_t     in_dstaddr,
   input  emesh_pkg::data_t     in_data,
   input  emesh_pkg::addr_t     in_srcaddr,
   // fifo write side
   fifo_wr_if.producer          wr
   );

   emesh_pkg::packet_t next_pkt;   // packed from the inputs
   emesh_pkg::packet_t stage_pkt;  // waiting for the fifo
   logic               stage_valid;
   logic               wr_fire;
   logic               accept;

   //##################################################
   // handshake
   //##################################################
   assign wr_fire  = stage_valid & ~wr.full;   // stage drains this cycle
   assign in_ready = ~stage_valid | wr_fire;   // empty or emptying
   assign accept   = in_valid & in_ready;

   assign wr.wr_en = wr_fire;
   assign wr.din   = stage_pkt;

   //##################################################
   // packing
   //##################################################
   always_comb
   begin
      next_pkt.write    = in_write;
      next_pkt.datamode = in_datamode;
      next_pkt.ctrlmode = in_ctrlmode;
      next_pkt.dstaddr  = in_dstaddr;
      next_pkt.data     = in_write ? in_data : '0;  // reads carry no payload
      next_pkt.srcaddr  = in_srcaddr;
   end

   // stage flag
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         stage_valid <= 1'b0;
      else if (clear)
         stage_valid <= 1'b0;  // flush drops the staged packet
      else if (accept)
         stage_valid <= 1'b1;
      else if (wr_fire)
         stage_valid <= 1'b0;
   end

   // stage payload
   always_ff @(posedge clk)
   begin
      if (accept)
         stage_pkt <= next_pkt;
   end

   // a stalled packet must reach the fifo unchanged
   a_stage_hold : assert property (@(posedge clk) disable iff (!nreset)
      (stage_valid && wr.full && !clear)
      |=> (stage_valid && stage_pkt == $past(stage_pkt)))
      else $error("packet_encoder: staged packet changed while stalled");

endmodule

//--- run.sh
#!/bin/sh
# build and run the emesh transaction buffer testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   -f tb.f \
   --top-module tb_emesh_fifo \
   -o tb_emesh_fifo

out=$(./obj_dir/tb_emesh_fifo)
echo "$out"

if echo "$out" | grep -q '^>>> PASS$'; then
   echo "simulation passed"
   exit 0
fi
echo "simulation failed"
exit 1

//--- sim/tb_emesh_fifo.sv
// emesh transaction buffer testbench
// random valid/ready traffic against a scoreboard, checked by assertions
`timescale 1ns/1ps
`include "emesh_defines.svh"

module tb_emesh_fifo;

   localparam int CAPACITY = `EMESH_FIFO_DEPTH + 3;  // fifo + skid store + stage
   localparam int TIMEOUT  = 5000;                   // cycles per wait loop

   logic                               clk;
   logic                               nreset;
   logic                               clear;
   logic                               in_valid;
   logic                               in_ready;
   logic                               in_write;
   emesh_pkg::datamode_t               in_datamode;
   emesh_pkg::ctrlmode_t               in_ctrlmode;
   emesh_pkg::addr_t                   in_dstaddr;
   emesh_pkg::data_t                   in_data;
   emesh_pkg::addr_t                   in_srcaddr;
   logic                               out_valid;
   logic                               out_ready;
   logic                               out_write;
   emesh_pkg::datamode_t               out_datamode;
   emesh_pkg::ctrlmode_t               out_ctrlmode;
   emesh_pkg::addr_t                   out_dstaddr;
   emesh_pkg::data_t                   out_data;
   emesh_pkg::addr_t                   out_srcaddr;
   logic                               almost_full;
   logic [$clog2(`EMESH_FIFO_DEPTH):0] fifo_level;

   emesh_pkg::packet_t sb_q [$];  // accepted, not yet delivered
   emesh_pkg::packet_t sb_head;   // expected next output
   emesh_pkg::packet_t out_pkt;   // output fields repacked
   emesh_pkg::packet_t prev_out;  // out_pkt one edge back
   int                 sb_count;
   logic               in_fire;   // input handshake on the last edge
   logic               fill_mode; // out_ready held low, path filling
   int                 value_errors;
   int                 state_errors;
   int                 timeouts;

   emesh_fifo_top dut_i (.*);

   assign out_pkt = {out_write, out_datamode, out_ctrlmode, out_dstaddr, out_data, out_srcaddr};

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;  // 20 ns
   end

   //##################################################
   // scoreboard
   //##################################################
   // expected packet for the access on the inputs
   function automatic emesh_pkg::packet_t build_expected();
      emesh_pkg::packet_t p;
      p.write    = in_write;
      p.datamode = in_datamode;
      p.ctrlmode = in_ctrlmode;
      p.dstaddr  = in_dstaddr;
      p.data     = in_write ? in_data : '0;  // reads deliver zero data
      p.srcaddr  = in_srcaddr;
      return p;
   endfunction

   always @(posedge clk)
   begin
      if (!nreset || clear)
         sb_q.delete();  // whole path empties
      else
      begin
         if (out_valid && out_ready && sb_q.size() > 0)
            void'(sb_q.pop_front());
         if (in_valid && in_ready)
            sb_q.push_back(build_expected());
      end
      sb_count <= sb_q.size();
      sb_head  <= (sb_q.size() > 0) ? sb_q[0] : '0;
      prev_out <= out_pkt;
      in_fire  <= in_valid && in_ready;
   end

   //##################################################
   // checks
   //##################################################
   a_reset_state : assert property (@(posedge clk)
      (!nreset || $rose(nreset)) |-> (in_ready && !out_valid && !almost_full))
      else
      begin
         state_errors++;
         $display("Fail %0t {in_ready,out_valid,almost_full}: expected 100 got %b",
                  $time, $sampled({in_ready, out_valid, almost_full}));
      end

   a_order : assert property (@(posedge clk) disable iff (!nreset)
      (out_valid && out_ready) |-> (sb_count > 0 && out_pkt == sb_head))
      else
      begin
         value_errors++;
         $display("Fail %0t out_pkt: expected %h got %h (%0d queued)",
                  $time, $sampled(sb_head), $sampled(out_pkt), $sampled(sb_count));
      end

   // stalled output holds
   a_hold : assert property (@(posedge clk) disable iff (!nreset)
      (out_valid && !out_ready && !clear) |=> (out_valid && out_pkt == prev_out))
      else
      begin
         value_errors++;
         $display("Fail %0t out_pkt held: expected %h got %h",
                  $time, $sampled(prev_out), $sampled(out_pkt));
      end

   a_almost_full : assert property (@(posedge clk) disable iff (!nreset)
      almost_full == (fifo_level >= `EMESH_PROG_FULL))
      else
      begin
         value_errors++;
         $display("Fail %0t almost_full: expected %b got %b (level %0d)", $time,
                  $sampled(fifo_level >= `EMESH_PROG_FULL), $sampled(almost_full),
                  $sampled(fifo_level));
      end

   a_capacity : assert property (@(posedge clk) disable iff (!nreset)
      (fill_mode && sb_count >= CAPACITY) |-> !in_ready)
      else
      begin
         value_errors++;
         $display("Fail %0t in_ready: expected 0 got 1 with %0d held", $time, $sampled(sb_count));
      end

   a_clear : assert property (@(posedge clk) disable iff (!nreset)
      clear |=> (!out_valid && in_ready && fifo_level == 0))
      else
      begin
         state_errors++;
         $display("Fail %0t {out_valid,in_ready,fifo_level} after clear: expected 01,0 got %b,%0d",
                  $time, $sampled({out_valid, in_ready}), $sampled(fifo_level));
      end

   //##################################################
   // stimulus
   //##################################################
   task automatic random_fields();
      in_write    = 1'($urandom_range(1));
      in_datamode = emesh_pkg::datamode_t'(2'($urandom_range(3)));
      in_ctrlmode = 5'($urandom);
      in_dstaddr  = $urandom;
      in_data     = $urandom;
      in_srcaddr  = $urandom;
   endtask

   // n accesses, valid held until taken
   task automatic run_traffic(input int n, input int valid_pct, input int ready_pct);
      int sent;
      int guard;
      sent  = 0;
      guard = 0;
      while (guard < n * 40)
      begin
         @(negedge clk);
         guard++;
         out_ready = (int'($urandom_range(99)) < ready_pct);
         if (!in_valid || in_fire)
         begin
            in_valid = 1'b0;
            if (sent == n)
               break;
            if (int'($urandom_range(99)) < valid_pct)
            begin
               random_fields();
               in_valid = 1'b1;
               sent++;
            end
         end
      end
      if (in_valid || sent < n)
      begin
         timeouts++;
         $display("timeout: only %0d of %0d accesses were accepted",
                  sent - int'(in_valid), n);
      end
   endtask

   task automatic drain_path();
      int guard;
      guard     = 0;
      in_valid  = 1'b0;
      out_ready = 1'b1;
      while (sb_count != 0 && guard < TIMEOUT)
      begin
         @(negedge clk);
         guard++;
      end
      if (sb_count != 0)
      begin
         timeouts++;
         $display("timeout: %0d accesses never left the buffer", sb_count);
      end
   endtask

   // push until in_ready stays low with the output blocked
   task automatic fill_path();
      int guard;
      int low_run;
      guard     = 0;
      low_run   = 0;
      out_ready = 1'b0;
      fill_mode = 1'b1;
      random_fields();
      in_valid  = 1'b1;
      while (low_run < 8 && guard < TIMEOUT)
      begin
         @(negedge clk);
         guard++;
         if (in_fire)
            random_fields();  // next access
         low_run = in_ready ? 0 : low_run + 1;
      end
      if (low_run < 8)
      begin
         timeouts++;
         $display("timeout: in_ready never stayed low while filling");
      end
      a_fill_count : assert (sb_count == CAPACITY)
      else
      begin
         value_errors++;
         $display("Fail %0t accepted count: expected %0d got %0d", $time, CAPACITY, sb_count);
      end
   endtask

   task automatic pulse_clear();
      in_valid  = 1'b0;
      out_ready = 1'b0;
      fill_mode = 1'b0;
      clear     = 1'b1;
      @(negedge clk);
      clear     = 1'b0;
   endtask

   initial
   begin
      void'($urandom(32'haa16));  // single seed for the run
      nreset       = 1'b0;
      clear        = 1'b0;
      in_valid     = 1'b0;
      in_write     = 1'b0;
      in_datamode  = emesh_pkg::DM_BYTE;
      in_ctrlmode  = '0;
      in_dstaddr   = '0;
      in_data      = '0;
      in_srcaddr   = '0;
      out_ready    = 1'b0;
      fill_mode    = 1'b0;
      value_errors = 0;
      state_errors = 0;
      timeouts     = 0;
      repeat (10) @(negedge clk);
      nreset = 1'b1;

      run_traffic(400, 70, 60);  // mixed traffic
      drain_path();
      run_traffic(200, 90, 25);  // heavy back-pressure
      drain_path();
      fill_path();
      pulse_clear();             // path is full here
      run_traffic(50, 60, 80);
      drain_path();
      repeat (4) @(negedge clk);

      $display("errors: value %0d, state %0d, timeout %0d", value_errors, state_errors, timeouts);
      if (value_errors + state_errors + timeouts == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

//--- tb.f
+incdir+hdl
hdl/emesh_pkg.sv
hdl/fifo_wr_if.sv
hdl/fifo_rd_if.sv
hdl/mem_dp.sv
hdl/fifo_sync.sv
hdl/packet_encoder.sv
hdl/packet_decoder.sv
hdl/emesh_fifo_top.sv
sim/tb_emesh_fifo.sv
